// ==== list.f ====
+incdir+design
design/ao_periph_pkg.sv
design/obi_reg_bridge.sv
design/reg_demux.sv
design/soc_ctrl.sv
design/fast_intr_ctrl.sv
design/ao_peripheral_subsystem.sv
verif/tb_ao_peripheral_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_ao_peripheral_subsystem
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST)) design/ao_periph_settings.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q '^TESTS PASSED$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_ao_peripheral_subsystem.sv ====
// **********************************************************************
// Testbench for the always-on peripheral subsystem with random OBI
// traffic checked against a register model
// **********************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "ao_periph_settings.svh"

module tb_ao_peripheral_subsystem;

  localparam int TIMEOUT = 200;
  localparam logic [31:0] SOC = `AO_SOC_CTRL_BASE;
  localparam logic [31:0] INTR = `AO_FAST_INTR_BASE;

  logic                    clk_i = 1'b0;
  logic                    arst_n_i;
  ao_periph_pkg::obi_req_t slave_req_i;
  ao_periph_pkg::obi_rsp_t slave_resp_o;
  logic                    boot_select_i;
  logic                    exit_valid_o;
  logic [31:0]             exit_value_o;
  logic [14:0]             fast_intr_i;
  logic [14:0]             fast_intr_o;

  // Expected responses in order with err in bit 32
  logic [32:0] exp_q[$];
  logic [32:0] exp_rsp;
  logic        m_exit_valid;
  logic [31:0] m_exit_value;
  logic [14:0] m_enable;
  logic [14:0] m_pending;
  integer      seed;

  ao_peripheral_subsystem DUT (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .slave_req_i   (slave_req_i),
    .slave_resp_o  (slave_resp_o),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o),
    .fast_intr_i   (fast_intr_i),
    .fast_intr_o   (fast_intr_o)
  );

  always #2 clk_i = ~clk_i;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  // Register model applied in acceptance order
  task automatic model_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [32:0] rsp);
    logic [31:0] ofs;
    logic [31:0] rdata;
    logic        err;
    ofs = addr % `AO_REGION_SIZE;
    rdata = '0;
    err = 1'b0;
    if (addr - ofs == SOC) begin
      if (ofs == `AO_EXIT_VALID_OFS) begin
        if (we) m_exit_valid = wdata[0];
        rdata = {31'b0, m_exit_valid};
      end else if (ofs == `AO_EXIT_VALUE_OFS) begin
        for (int b = 0; b < 4; b++) begin
          if (we && be[b]) m_exit_value[8*b +: 8] = wdata[8*b +: 8];
        end
        rdata = m_exit_value;
      end else if (ofs == `AO_BOOT_SEL_OFS) begin
        rdata = {31'b0, boot_select_i};
      end else begin
        err = 1'b1;
      end
    end else if (addr - ofs == INTR) begin
      if (ofs == `AO_INTR_PENDING_OFS) begin
        rdata = {17'b0, m_pending};
      end else if (ofs == `AO_INTR_ENABLE_OFS) begin
        for (int i = 0; i < 15; i++) begin
          if (we && be[i/8]) m_enable[i] = wdata[i];
        end
        rdata = {17'b0, m_enable};
      end else if (ofs == `AO_INTR_CLEAR_OFS) begin
        // Lines still high set their bit again
        if (we) m_pending = (m_pending & ~wdata[14:0]) | fast_intr_i;
      end else begin
        err = 1'b1;
      end
    end else begin
      err = 1'b1;
    end
    rsp = {err, we ? 32'h0 : rdata};
  endtask

  // Called on a rising edge and returns on the edge that accepts the request
  task automatic send(input logic we, input logic [3:0] be, input logic [31:0] addr,
                      input logic [31:0] wdata);
    logic [32:0] rsp;
    logic        accepted;
    int          waited;
    slave_req_i <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    accepted = 1'b0;
    waited = 0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = slave_resp_o.gnt;
      @(posedge clk_i);
      waited++;
      if (waited > TIMEOUT) stop_run("Timeout: request was never granted");
    end
    model_access(we, be, addr, wdata, rsp);
    exp_q.push_back(rsp);
  endtask

  task automatic drain();
    int waited;
    slave_req_i <= '0;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      waited++;
      if (waited > TIMEOUT) stop_run("Timeout: a response never arrived");
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  always @(negedge clk_i) begin
    if (arst_n_i && slave_resp_o.rvalid) begin
      if (exp_q.size() == 0) begin
        stop_run("Response arrived with no request outstanding");
      end else begin
        exp_rsp = exp_q.pop_front();
        check_value("rdata", slave_resp_o.rdata, exp_rsp[31:0]);
        check_value("err", {31'b0, slave_resp_o.err}, {31'b0, exp_rsp[32]});
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] ofs;
    seed = 88;
    slave_req_i = '0;
    boot_select_i = 1'b0;
    fast_intr_i = '0;
    arst_n_i = 1'b0;
    m_exit_valid = 1'b0;
    m_exit_value = '0;
    m_enable = '1;
    m_pending = '0;
    idle_cycles(5);
    arst_n_i <= 1'b1;
    @(posedge clk_i);

    check_value("exit_valid_o", {31'b0, exit_valid_o}, 32'h0);
    check_value("exit_value_o", exit_value_o, 32'h0);
    check_value("fast_intr_o", {17'b0, fast_intr_o}, 32'h0);
    send(1'b0, 4'hF, INTR + `AO_INTR_ENABLE_OFS, 32'h0);
    drain();

    // Byte merges on the exit value
    repeat (20) begin
      r = rand32();
      r2 = rand32();
      send(1'b1, r2[3:0], SOC + `AO_EXIT_VALUE_OFS, r);
      send(1'b0, 4'hF, SOC + `AO_EXIT_VALUE_OFS, 32'h0);
      drain();
      check_value("exit_value_o", exit_value_o, m_exit_value);
    end

    send(1'b1, 4'hF, SOC + `AO_EXIT_VALID_OFS, 32'h1);
    drain();
    check_value("exit_valid_o", {31'b0, exit_valid_o}, 32'h1);
    for (int lvl = 0; lvl < 2; lvl++) begin
      boot_select_i <= lvl[0];
      idle_cycles(2);
      send(1'b0, 4'hF, SOC + `AO_BOOT_SEL_OFS, 32'h0);
      drain();
    end

    // Interrupt lines only move while the bus is idle
    repeat (30) begin
      r = rand32();
      fast_intr_i <= r[14:0] & r[30:16];
      idle_cycles(2);
      m_pending = m_pending | fast_intr_i;
      if (r[31]) begin
        fast_intr_i <= '0;
        idle_cycles(2);
      end
      r = rand32();
      r2 = rand32();
      send(1'b1, r2[3:0], INTR + `AO_INTR_ENABLE_OFS, r | 32'h0000_5a5a);
      send(1'b1, 4'hF, INTR + `AO_INTR_CLEAR_OFS, r2);
      send(1'b0, 4'hF, INTR + `AO_INTR_PENDING_OFS, 32'h0);
      send(1'b0, 4'hF, INTR + `AO_INTR_ENABLE_OFS, 32'h0);
      drain();
      idle_cycles(2);
      check_value("fast_intr_o", {17'b0, fast_intr_o}, {17'b0, m_pending & m_enable});
    end
    fast_intr_i <= '0;
    idle_cycles(2);

    // Back-to-back unmapped addresses and unknown offsets
    repeat (25) begin
      r = rand32();
      r2 = rand32();
      if (r[31:13] == '0) r[13] = 1'b1;
      send(r2[0], r2[7:4], r, r2);
      ofs = {20'b0, r[11:0]};
      if (ofs < 12) ofs = ofs + 12;
      send(r2[2], r2[7:4], (r2[1] ? INTR : SOC) + ofs, r);
      send(1'b0, 4'hF, SOC + `AO_EXIT_VALUE_OFS, 32'h0);
    end
    drain();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/ao_peripheral_subsystem.sv ====
// **********************************************************************
// Always-on peripheral subsystem with SoC control and fast interrupts
// **********************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "ao_periph_settings.svh"

module ao_peripheral_subsystem (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  ao_periph_pkg::obi_req_t    slave_req_i,
  output ao_periph_pkg::obi_rsp_t    slave_resp_o,
  input  logic                       boot_select_i,
  output logic                       exit_valid_o,
  output logic [31:0]                exit_value_o,
  input  logic [`AO_FAST_INTR_N-1:0] fast_intr_i,
  output logic [`AO_FAST_INTR_N-1:0] fast_intr_o
);

  ao_periph_pkg::reg_req_t periph_req;
  ao_periph_pkg::reg_rsp_t periph_rsp;
  ao_periph_pkg::reg_req_t soc_ctrl_req;
  ao_periph_pkg::reg_rsp_t soc_ctrl_rsp;
  ao_periph_pkg::reg_req_t fast_intr_req;
  ao_periph_pkg::reg_rsp_t fast_intr_rsp;

  obi_reg_bridge obi_reg_bridge_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .obi_req_i (slave_req_i),
    .obi_rsp_o (slave_resp_o),
    .reg_req_o (periph_req),
    .reg_rsp_i (periph_rsp)
  );

  reg_demux reg_demux_i (
    .reg_req_i       (periph_req),
    .reg_rsp_o       (periph_rsp),
    .soc_ctrl_req_o  (soc_ctrl_req),
    .soc_ctrl_rsp_i  (soc_ctrl_rsp),
    .fast_intr_req_o (fast_intr_req),
    .fast_intr_rsp_i (fast_intr_rsp),
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .reg_req_i     (soc_ctrl_req),
    .reg_rsp_o     (soc_ctrl_rsp),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .reg_req_i   (fast_intr_req),
    .reg_rsp_o   (fast_intr_rsp),
    .fast_intr_i (fast_intr_i),
    .fast_intr_o (fast_intr_o)
  );

endmodule

`default_nettype wire

// ==== design/fast_intr_ctrl.sv ====
// **********************************************************************
// Fast interrupt controller with pending, enable and clear registers
// **********************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "ao_periph_settings.svh"

module fast_intr_ctrl (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  ao_periph_pkg::reg_req_t    reg_req_i,
  output ao_periph_pkg::reg_rsp_t    reg_rsp_o,
  input  logic [`AO_FAST_INTR_N-1:0] fast_intr_i,
  output logic [`AO_FAST_INTR_N-1:0] fast_intr_o
);

  logic [`AO_FAST_INTR_N-1:0] pending_q;
  logic [`AO_FAST_INTR_N-1:0] enable_q;
  logic [`AO_FAST_INTR_N-1:0] intr_q;
  logic [`AO_FAST_INTR_N-1:0] clr_mask;

  logic is_pend;
  logic is_en;
  logic is_clr;
  logic wr_en;

  assign is_pend = (reg_req_i.addr == `AO_INTR_PENDING_OFS);
  assign is_en   = (reg_req_i.addr == `AO_INTR_ENABLE_OFS);
  assign is_clr  = (reg_req_i.addr == `AO_INTR_CLEAR_OFS);
  assign wr_en   = reg_req_i.valid & reg_req_i.write;

  assign clr_mask = (wr_en && is_clr) ? reg_req_i.wdata[`AO_FAST_INTR_N-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      enable_q  <= '1;
      intr_q    <= '0;
    end else begin
      // A new event wins over a clear in the same cycle
      pending_q <= (pending_q & ~clr_mask) | fast_intr_i;
      intr_q    <= pending_q & enable_q;
      if (wr_en && is_en) begin
        for (int i = 0; i < `AO_FAST_INTR_N; i++) begin
          if (reg_req_i.wstrb[i/8]) begin
            enable_q[i] <= reg_req_i.wdata[i];
          end
        end
      end
    end
  end

  always_comb begin
    reg_rsp_o       = '0;
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = ~(is_pend | is_en | is_clr);
    if (!reg_req_i.write) begin
      if (is_pend) begin
        reg_rsp_o.rdata[`AO_FAST_INTR_N-1:0] = pending_q;
      end else if (is_en) begin
        reg_rsp_o.rdata[`AO_FAST_INTR_N-1:0] = enable_q;
      end
    end
  end

  assign fast_intr_o = intr_q;

endmodule

`default_nettype wire

// ==== design/soc_ctrl.sv ====
// **********************************************************************
// SoC control registers for exit status and boot select
// **********************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "ao_periph_settings.svh"

module soc_ctrl (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic                    boot_select_i,
  output logic                    exit_valid_o,
  output logic [31:0]             exit_value_o
);

  logic                  exit_valid_q;
  logic [`AO_DATA_W-1:0] exit_value_q;

  logic is_valid;
  logic is_value;
  logic is_boot;
  logic wr_en;

  assign is_valid = (reg_req_i.addr == `AO_EXIT_VALID_OFS);
  assign is_value = (reg_req_i.addr == `AO_EXIT_VALUE_OFS);
  assign is_boot  = (reg_req_i.addr == `AO_BOOT_SEL_OFS);
  assign wr_en    = reg_req_i.valid & reg_req_i.write;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else begin
      if (wr_en && is_valid) begin
        exit_valid_q <= reg_req_i.wdata[0];
      end
      if (wr_en && is_value) begin
        for (int b = 0; b < `AO_BE_W; b++) begin
          if (reg_req_i.wstrb[b]) begin
            exit_value_q[8*b +: 8] <= reg_req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Boot select is read only
  always_comb begin
    reg_rsp_o       = '0;
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = ~(is_valid | is_value | is_boot);
    if (!reg_req_i.write) begin
      if (is_valid) begin
        reg_rsp_o.rdata[0] = exit_valid_q;
      end else if (is_value) begin
        reg_rsp_o.rdata = exit_value_q;
      end else if (is_boot) begin
        reg_rsp_o.rdata[0] = boot_select_i;
      end
    end
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

`default_nettype wire

// ==== design/reg_demux.sv ====
// **********************************************************************
// Register bus decoder routing accesses to the peripheral regions
// **********************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "ao_periph_settings.svh"

module reg_demux (
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  output ao_periph_pkg::reg_req_t soc_ctrl_req_o,
  input  ao_periph_pkg::reg_rsp_t soc_ctrl_rsp_i,
  output ao_periph_pkg::reg_req_t fast_intr_req_o,
  input  ao_periph_pkg::reg_rsp_t fast_intr_rsp_i,
  input  logic                    clk_i,
  input  logic                    arst_n_i
);

  localparam logic [`AO_ADDR_W-1:0] OFS_MASK = `AO_REGION_SIZE - 1;

  ao_periph_pkg::reg_rsp_t [ao_periph_pkg::AO_PERIPHERALS-1:0] rsp_vec;
  ao_periph_pkg::periph_idx_e sel;

  logic                  hit_soc;
  logic                  hit_intr;
  logic                  mapped;
  logic [`AO_ADDR_W-1:0] offset;

  // Region match on the upper address bits
  assign hit_soc  = ((reg_req_i.addr & ~OFS_MASK) == `AO_SOC_CTRL_BASE);
  assign hit_intr = ((reg_req_i.addr & ~OFS_MASK) == `AO_FAST_INTR_BASE);
  assign mapped   = hit_soc | hit_intr;
  assign offset   = reg_req_i.addr & OFS_MASK;

  assign sel = hit_intr ? ao_periph_pkg::IDX_FAST_INTR : ao_periph_pkg::IDX_SOC_CTRL;

  always_comb begin
    soc_ctrl_req_o       = reg_req_i;
    soc_ctrl_req_o.valid = reg_req_i.valid & hit_soc;
    soc_ctrl_req_o.addr  = offset;

    fast_intr_req_o       = reg_req_i;
    fast_intr_req_o.valid = reg_req_i.valid & hit_intr;
    fast_intr_req_o.addr  = offset;
  end

  assign rsp_vec[ao_periph_pkg::IDX_SOC_CTRL]  = soc_ctrl_rsp_i;
  assign rsp_vec[ao_periph_pkg::IDX_FAST_INTR] = fast_intr_rsp_i;

  // Unmapped accesses complete at once with an error
  always_comb begin
    if (mapped) begin
      reg_rsp_o = rsp_vec[sel];
    end else begin
      reg_rsp_o       = '0;
      reg_rsp_o.ready = 1'b1;
      reg_rsp_o.error = 1'b1;
    end
  end

  a_single_target: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({soc_ctrl_req_o.valid, fast_intr_req_o.valid}));

endmodule

`default_nettype wire

// ==== design/obi_reg_bridge.sv ====
// **********************************************************************
// OBI slave with a small request queue, issuing in-order register
// bus accesses and returning one registered response per request
// **********************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "ao_periph_settings.svh"

module obi_reg_bridge (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  ao_periph_pkg::obi_req_t obi_req_i,
  output ao_periph_pkg::obi_rsp_t obi_rsp_o,
  output ao_periph_pkg::reg_req_t reg_req_o,
  input  ao_periph_pkg::reg_rsp_t reg_rsp_i
);

  localparam int unsigned DEPTH = `AO_REQ_QUEUE_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  ao_periph_pkg::reg_req_t q_mem [DEPTH];
  ao_periph_pkg::reg_req_t entry;

  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  logic                  rvalid_q;
  logic                  err_q;
  logic [`AO_DATA_W-1:0] rdata_q;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = obi_req_i.req & obi_rsp_o.gnt;
  assign pop  = reg_req_o.valid & reg_rsp_i.ready;

  always_comb begin
    entry       = '0;
    entry.valid = 1'b1;
    entry.write = obi_req_i.we;
    entry.addr  = obi_req_i.addr;
    entry.wdata = obi_req_i.wdata;
    entry.wstrb = obi_req_i.be;
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      q_mem[tail_q] <= entry;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        tail_q <= ptr_inc(tail_q);
      end
      if (pop) begin
        head_q <= ptr_inc(head_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Head of queue drives the register bus
  always_comb begin
    reg_req_o       = q_mem[head_q];
    reg_req_o.valid = (count_q != '0);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= pop;
    end
  end

  // Write responses carry no data
  always_ff @(posedge clk_i) begin
    if (pop) begin
      err_q   <= reg_rsp_i.error;
      rdata_q <= reg_req_o.write ? '0 : reg_rsp_i.rdata;
    end
  end

  // Grant while a slot is free
  always_comb begin
    obi_rsp_o.gnt    = (count_q != CNT_W'(DEPTH));
    obi_rsp_o.rvalid = rvalid_q;
    obi_rsp_o.err    = err_q;
    obi_rsp_o.rdata  = rdata_q;
  end

  a_no_accept_when_full: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    push |-> (count_q < CNT_W'(DEPTH)));

  // Pointers meet only when the queue is empty or full
  a_ptr_count_match: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (head_q == tail_q) == ((count_q == '0) || (count_q == CNT_W'(DEPTH))));

endmodule

`default_nettype wire

// ==== design/ao_periph_pkg.sv ====
// **********************************************************************
// Bus types and peripheral indices of the always-on subsystem
// **********************************************************************

`default_nettype none

`include "ao_periph_settings.svh"

package ao_periph_pkg;

  // OBI request from the bus master
  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [`AO_BE_W-1:0]   be;
    logic [`AO_ADDR_W-1:0] addr;
    logic [`AO_DATA_W-1:0] wdata;
  } obi_req_t;

  // OBI response with gnt in the address phase and the rest in the response phase
  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic                  err;
    logic [`AO_DATA_W-1:0] rdata;
  } obi_rsp_t;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [`AO_ADDR_W-1:0] addr;
    logic [`AO_DATA_W-1:0] wdata;
    logic [`AO_BE_W-1:0]   wstrb;
  } reg_req_t;

  typedef struct packed {
    logic                  ready;
    logic                  error;
    logic [`AO_DATA_W-1:0] rdata;
  } reg_rsp_t;

  typedef enum logic [0:0] {
    IDX_SOC_CTRL  = 1'b0,
    IDX_FAST_INTR = 1'b1
  } periph_idx_e;

  localparam int unsigned AO_PERIPHERALS = 2;

endpackage

`default_nettype wire

// ==== design/ao_periph_settings.svh ====
// **********************************************************************
// Always-on peripheral settings for bus widths, queue depth and map
// **********************************************************************

`ifndef AO_PERIPH_SETTINGS_SVH
`define AO_PERIPH_SETTINGS_SVH

// Bus widths
`define AO_ADDR_W 32
`define AO_DATA_W 32
`define AO_BE_W 4

`define AO_FAST_INTR_N 15
`define AO_REQ_QUEUE_DEPTH 2

// Address map regions are aligned to their size
`define AO_SOC_CTRL_BASE 32'h0000_0000
`define AO_FAST_INTR_BASE 32'h0000_1000
`define AO_REGION_SIZE 32'h0000_1000

// SoC control offsets
`define AO_EXIT_VALID_OFS 32'h0
`define AO_EXIT_VALUE_OFS 32'h4
`define AO_BOOT_SEL_OFS 32'h8

// Fast interrupt controller offsets
`define AO_INTR_PENDING_OFS 32'h0
`define AO_INTR_ENABLE_OFS 32'h4
`define AO_INTR_CLEAR_OFS 32'h8

`endif
